// ==== calsoc_pkg.sv ====
package calsoc_pkg;

	////////////////////////////////////////
	// Wishbone bus types
	////////////////////////////////////////

	// Byte address as seen on the bus
	typedef logic [31:0] wb_adr_t;

	// One bus data word
	typedef logic [31:0] wb_dat_t;

	// Byte enables, one per byte lane
	typedef logic [3:0]  wb_sel_t;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Region base addresses
	localparam wb_adr_t RAM_BASE    = 32'h0000_0000;
	localparam wb_adr_t MU_BASE     = 32'h0100_0000;

	// Top byte selects the region, the rest is the offset inside it
	localparam wb_adr_t REGION_MASK = 32'hFF00_0000;

endpackage

// ==== mu_pkg.sv ====
package mu_pkg;

	// Comparator threshold code, goes to the DAC as is
	typedef logic [15:0] thr_t;

	// Number of points in one sweep
	typedef logic [15:0] cnt_t;

	////////////////////////////////////////
	// Register byte offsets
	////////////////////////////////////////
	localparam logic [31:0] REG_CTRL   = 32'h00;	// bit 0 starts a sweep
	localparam logic [31:0] REG_START  = 32'h04;
	localparam logic [31:0] REG_STEP   = 32'h08;
	localparam logic [31:0] REG_COUNT  = 32'h0C;
	localparam logic [31:0] REG_DEST   = 32'h10;	// RAM byte address of result 0
	localparam logic [31:0] REG_STATUS = 32'h14;	// bit 0 busy, bit 1 done

	// Result word bit that carries the comparator sample
	localparam int RESULT_CMP_BIT = 31;

	// Sweep sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SET,
		SETTLE,
		WRITE,
		DONE
	} mu_state_e;

endpackage

// ==== wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;
	import calsoc_pkg::*;

	// Master to slave
	logic    cyc;
	logic    stb;
	logic    we;
	wb_adr_t adr;
	wb_dat_t dat_m2s;
	wb_sel_t sel;

	// Slave to master
	wb_dat_t dat_s2m;
	logic    ack;
	logic    err;

	modport master (
		output cyc, stb, we, adr, dat_m2s, sel,
		input  dat_s2m, ack, err
	);

	modport slave (
		input  cyc, stb, we, adr, dat_m2s, sel,
		output dat_s2m, ack, err
	);

endinterface

// ==== wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
	input logic  wb_clk_i,
	input logic  rst_n_i,
	wb_if.slave  host_m,
	wb_if.slave  mu_m,
	wb_if.master bus_o
);

	// Grant, 0 is the host and 1 the measure unit
	logic gnt_q;
	logic gnt_d;
	// Master that held the bus most recently
	logic last_q;
	// Cycle line of the master that owns the bus now
	logic own_cyc;

	assign own_cyc = gnt_q ? mu_m.cyc : host_m.cyc;

	// Re-arbitrate only while the owner is idle
	always_comb begin
		gnt_d = gnt_q;
		if (!own_cyc) begin
			if (host_m.cyc && mu_m.cyc)
				gnt_d = ~last_q;
			else if (host_m.cyc)
				gnt_d = 1'b0;
			else if (mu_m.cyc)
				gnt_d = 1'b1;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			gnt_q  <= 1'b0;
			last_q <= 1'b1;	// host wins the first tie
		end else begin
			gnt_q <= gnt_d;
			if (own_cyc)
				last_q <= gnt_q;
		end
	end

	////////////////////////////////////////
	// Request mux
	////////////////////////////////////////
	assign bus_o.cyc     = own_cyc;
	assign bus_o.stb     = gnt_q ? mu_m.stb     : host_m.stb;
	assign bus_o.we      = gnt_q ? mu_m.we      : host_m.we;
	assign bus_o.adr     = gnt_q ? mu_m.adr     : host_m.adr;
	assign bus_o.dat_m2s = gnt_q ? mu_m.dat_m2s : host_m.dat_m2s;
	assign bus_o.sel     = gnt_q ? mu_m.sel     : host_m.sel;

	// Responses go back to the owner only
	assign host_m.ack     = bus_o.ack & ~gnt_q;
	assign host_m.err     = bus_o.err & ~gnt_q;
	assign host_m.dat_s2m = gnt_q ? '0 : bus_o.dat_s2m;
	assign mu_m.ack       = bus_o.ack & gnt_q;
	assign mu_m.err       = bus_o.err & gnt_q;
	assign mu_m.dat_s2m   = gnt_q ? bus_o.dat_s2m : '0;

endmodule

// ==== wb_decoder.sv ====
`timescale 1ns/1ps

module wb_decoder #(
	parameter int RAM_WORDS = 256
) (
	input logic  wb_clk_i,
	input logic  rst_n_i,
	wb_if.slave  bus_i,
	wb_if.master ram_o,
	wb_if.master reg_o
);
	import calsoc_pkg::*;
	import mu_pkg::*;

	localparam wb_adr_t RAM_BYTES = wb_adr_t'(RAM_WORDS * 4);

	wb_adr_t ofs;
	logic    ram_hit;
	logic    reg_hit;
	logic    req;
	logic    err_q;

	////////////////////////////////////////
	// Region match
	////////////////////////////////////////
	assign ofs     = bus_i.adr & ~REGION_MASK;
	assign ram_hit = ((bus_i.adr & REGION_MASK) == RAM_BASE) && (ofs < RAM_BYTES);
	assign reg_hit = ((bus_i.adr & REGION_MASK) == MU_BASE) && (ofs <= REG_STATUS);
	assign req     = bus_i.cyc && bus_i.stb;

	// Only the selected slave sees the cycle
	assign ram_o.cyc     = bus_i.cyc & ram_hit;
	assign ram_o.stb     = bus_i.stb & ram_hit;
	assign ram_o.we      = bus_i.we;
	assign ram_o.adr     = bus_i.adr;
	assign ram_o.dat_m2s = bus_i.dat_m2s;
	assign ram_o.sel     = bus_i.sel;

	assign reg_o.cyc     = bus_i.cyc & reg_hit;
	assign reg_o.stb     = bus_i.stb & reg_hit;
	assign reg_o.we      = bus_i.we;
	assign reg_o.adr     = bus_i.adr;
	assign reg_o.dat_m2s = bus_i.dat_m2s;
	assign reg_o.sel     = bus_i.sel;

	// Unmapped address, answer with a one-cycle err
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= req && !ram_hit && !reg_hit && !err_q;
	end

	////////////////////////////////////////
	// Response mux
	////////////////////////////////////////
	assign bus_i.ack     = ram_o.ack | reg_o.ack;
	assign bus_i.err     = err_q | ram_o.err | reg_o.err;
	assign bus_i.dat_s2m = ram_hit ? ram_o.dat_s2m :
	                       reg_hit ? reg_o.dat_s2m : '0;

endmodule

// ==== wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram #(
	parameter int RAM_WORDS = 256
) (
	input logic wb_clk_i,
	input logic rst_n_i,
	wb_if.slave bus_i
);
	import calsoc_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	wb_dat_t         mem [RAM_WORDS];
	wb_dat_t         rd_q;
	logic            ack_q;
	logic            req;
	logic [AW-1:0]   idx;

	// Word index, byte lanes are handled by sel
	assign idx = bus_i.adr[AW+1:2];
	assign req = bus_i.cyc && bus_i.stb && !ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	// Byte-enable write and registered read
	always_ff @(posedge wb_clk_i) begin
		if (req) begin
			if (bus_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (bus_i.sel[b])
						mem[idx][8*b +: 8] <= bus_i.dat_m2s[8*b +: 8];
				end
			end
			rd_q <= mem[idx];
		end
	end

	assign bus_i.dat_s2m = rd_q;
	assign bus_i.ack     = ack_q;
	assign bus_i.err     = 1'b0;

endmodule

// ==== measure_unit.sv ====
`timescale 1ns/1ps

module measure_unit #(
	parameter int SETTLE_CYCLES = 4
) (
	input  logic         wb_clk_i,
	input  logic         rst_n_i,
	wb_if.slave          regs_i,
	wb_if.master         bus_o,
	input  logic         cmp_i,
	output mu_pkg::thr_t dac_code_o,
	output logic         busy_o
);
	import calsoc_pkg::*;
	import mu_pkg::*;

	localparam int SW = $clog2(SETTLE_CYCLES + 1);

	// Register file
	thr_t      start_q;
	thr_t      step_q;
	cnt_t      count_q;
	wb_adr_t   dest_q;
	logic      done_q;

	// Register port
	wb_adr_t   ofs;
	wb_dat_t   rd_dat;
	wb_dat_t   wr_dat;
	wb_dat_t   reg_dat_q;
	logic      reg_ack_q;
	logic      reg_req;
	logic      reg_wr;
	logic      start_req;

	// Sequencer
	mu_state_e state_q;
	logic [SW-1:0] settle_q;
	cnt_t      idx_q;
	thr_t      thr_q;
	thr_t      dac_q;
	wb_dat_t   res_d;
	wb_dat_t   res_q;
	wb_adr_t   wr_adr_q;

	function automatic wb_dat_t merge_bytes(wb_dat_t old_v, wb_dat_t new_v, wb_sel_t sel);
		wb_dat_t v;
		v = old_v;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				v[8*b +: 8] = new_v[8*b +: 8];
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Register block
	////////////////////////////////////////
	assign ofs       = regs_i.adr & ~REGION_MASK;
	assign reg_req   = regs_i.cyc && regs_i.stb && !reg_ack_q;
	assign reg_wr    = reg_req && regs_i.we;
	assign wr_dat    = merge_bytes(rd_dat, regs_i.dat_m2s, regs_i.sel);
	// Start is honoured only from idle
	assign start_req = reg_wr && (ofs == REG_CTRL) && wr_dat[0] && (state_q == IDLE);

	always_comb begin
		case (ofs)
			REG_START:  rd_dat = wb_dat_t'(start_q);
			REG_STEP:   rd_dat = wb_dat_t'(step_q);
			REG_COUNT:  rd_dat = wb_dat_t'(count_q);
			REG_DEST:   rd_dat = dest_q;
			REG_STATUS: rd_dat = {30'h0, done_q, busy_o};
			default:    rd_dat = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			reg_ack_q <= 1'b0;
			start_q   <= '0;
			step_q    <= '0;
			count_q   <= '0;
			dest_q    <= '0;
		end else begin
			reg_ack_q <= reg_req;
			if (reg_wr) begin
				case (ofs)
					REG_START: start_q <= wr_dat[15:0];
					REG_STEP:  step_q  <= wr_dat[15:0];
					REG_COUNT: count_q <= wr_dat[15:0];
					REG_DEST:  dest_q  <= wr_dat;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (reg_req)
			reg_dat_q <= rd_dat;
	end

	assign regs_i.dat_s2m = reg_dat_q;
	assign regs_i.ack     = reg_ack_q;
	assign regs_i.err     = 1'b0;

	////////////////////////////////////////
	// Sweep sequencer
	////////////////////////////////////////

	// Threshold in the low half, comparator sample on top
	always_comb begin
		res_d = '0;
		res_d[15:0] = thr_q;
		res_d[RESULT_CMP_BIT] = cmp_i;
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			state_q  <= IDLE;
			settle_q <= '0;
			idx_q    <= '0;
			thr_q    <= '0;
			dac_q    <= '0;
			done_q   <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_req) begin
						done_q  <= 1'b0;
						idx_q   <= '0;
						thr_q   <= start_q;
						state_q <= (count_q == '0) ? DONE : SET;
					end
				end
				SET: begin
					dac_q    <= thr_q;
					settle_q <= '0;
					state_q  <= SETTLE;
				end
				SETTLE: begin
					settle_q <= settle_q + 1'b1;
					if (settle_q == SW'(SETTLE_CYCLES - 1))
						state_q <= WRITE;
				end
				WRITE: begin
					// Either response ends the transfer
					if (bus_o.ack || bus_o.err) begin
						idx_q <= idx_q + 1'b1;
						if (idx_q + 16'd1 == count_q) begin
							state_q <= DONE;
						end else begin
							thr_q   <= thr_q + step_q;
							state_q <= SET;
						end
					end
				end
				DONE: begin
					done_q  <= 1'b1;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Result and its address are frozen for the whole bus transfer
	always_ff @(posedge wb_clk_i) begin
		if (state_q == SETTLE && settle_q == SW'(SETTLE_CYCLES - 1)) begin
			res_q    <= res_d;
			wr_adr_q <= dest_q + (wb_adr_t'(idx_q) << 2);
		end
	end

	// Master side, one single write per point
	assign bus_o.cyc     = (state_q == WRITE);
	assign bus_o.stb     = (state_q == WRITE);
	assign bus_o.we      = 1'b1;
	assign bus_o.adr     = wr_adr_q;
	assign bus_o.dat_m2s = res_q;
	assign bus_o.sel     = '1;

	assign dac_code_o = dac_q;
	assign busy_o     = (state_q == SET) || (state_q == SETTLE) || (state_q == WRITE);

endmodule

// ==== calsoc_top.sv ====
`timescale 1ns/1ps

module calsoc_top #(
	parameter int RAM_WORDS     = 256,
	parameter int SETTLE_CYCLES = 4
) (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	// Host port
	input  logic                host_cyc_i,
	input  logic                host_stb_i,
	input  logic                host_we_i,
	input  calsoc_pkg::wb_adr_t host_adr_i,
	input  calsoc_pkg::wb_dat_t host_dat_i,
	input  calsoc_pkg::wb_sel_t host_sel_i,
	output calsoc_pkg::wb_dat_t host_dat_o,
	output logic                host_ack_o,
	output logic                host_err_o,
	// Comparator and DAC
	input  logic                cmp_i,
	output mu_pkg::thr_t        dac_code_o,
	output logic                busy_o
);

	wb_if host_bus ();
	wb_if mu_bus ();
	wb_if shared_bus ();
	wb_if ram_bus ();
	wb_if reg_bus ();

	////////////////////////////////////////
	// Host port onto its bus
	////////////////////////////////////////
	assign host_bus.cyc     = host_cyc_i;
	assign host_bus.stb     = host_stb_i;
	assign host_bus.we      = host_we_i;
	assign host_bus.adr     = host_adr_i;
	assign host_bus.dat_m2s = host_dat_i;
	assign host_bus.sel     = host_sel_i;
	assign host_dat_o       = host_bus.dat_s2m;
	assign host_ack_o       = host_bus.ack;
	assign host_err_o       = host_bus.err;

	////////////////////////////////////////
	// Bus fabric
	////////////////////////////////////////
	wb_arbiter u_arbiter (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.host_m   (host_bus.slave),
		.mu_m     (mu_bus.slave),
		.bus_o    (shared_bus.master)
	);

	wb_decoder #(
		.RAM_WORDS (RAM_WORDS)
	) u_decoder (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.bus_i    (shared_bus.slave),
		.ram_o    (ram_bus.master),
		.reg_o    (reg_bus.master)
	);

	////////////////////////////////////////
	// Slaves
	////////////////////////////////////////
	wb_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.bus_i    (ram_bus.slave)
	);

	measure_unit #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) u_measure_unit (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.regs_i     (reg_bus.slave),
		.bus_o      (mu_bus.master),
		.cmp_i      (cmp_i),
		.dac_code_o (dac_code_o),
		.busy_o     (busy_o)
	);

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_o
);

	// Free running, starts low
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

// ==== calsoc_assert.sv ====
`timescale 1ns/1ps

module calsoc_assert (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic gnt_q,
	input logic bus_cyc,
	input logic bus_stb,
	input logic bus_ack,
	input logic bus_err,
	input logic host_cyc,
	input logic host_stb,
	input logic host_ack,
	input logic mu_cyc,
	input logic mu_stb,
	input logic mu_ack
);

	////////////////////////////////////////
	// Wishbone protocol on the shared bus
	////////////////////////////////////////
	a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		bus_stb |-> bus_cyc)
		else $error("stb raised without cyc on the shared bus");

	a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		!(bus_ack && bus_err))
		else $error("ack and err high together on the shared bus");

	////////////////////////////////////////
	// Arbiter grant
	////////////////////////////////////////

	// Ack lands only on a master with its request up
	a_host_ack_req: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		host_ack |-> (host_cyc && host_stb))
		else $error("host saw ack without an open request");

	a_mu_ack_req: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		mu_ack |-> (mu_cyc && mu_stb))
		else $error("measure unit saw ack without an open request");

	// Owner keeps cyc and the grant until its response
	a_gnt_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(bus_cyc && !bus_ack && !bus_err) |=> (bus_cyc && $stable(gnt_q)))
		else $error("bus owner or grant changed before the response");

endmodule

// ==== calsoc_tb.sv ====
`timescale 1ns/1ps

module calsoc_tb;
	import calsoc_pkg::*;
	import mu_pkg::*;

	localparam int   RAM_WORDS     = 256;
	localparam int   SETTLE_CYCLES = 4;
	localparam thr_t TRIP_LEVEL    = 16'h0040;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_THR, OP_BUSY} op_e;

	logic    clk;
	logic    rst_n;
	logic    host_cyc;
	logic    host_stb;
	logic    host_we;
	wb_adr_t host_adr;
	wb_dat_t host_dat;
	wb_sel_t host_sel;
	wb_dat_t host_rdat;
	logic    host_ack;
	logic    host_err;
	logic    cmp;
	thr_t    dac_code;
	logic    busy;

	// Stimulus table, one entry per test
	op_e     op_q [$];
	wb_adr_t adr_q [$];
	wb_dat_t dat_q [$];
	wb_sel_t sel_q [$];
	wb_dat_t exp_q [$];
	logic    experr_q [$];

	wb_dat_t     ram_model [RAM_WORDS];
	integer      seed;
	int          err_cnt;
	int          fail_cnt;
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;

	tb_clk_gen #(.PERIOD_NS(100)) u_clk (.clk_o(clk));

	calsoc_top #(
		.RAM_WORDS     (RAM_WORDS),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) u_dut (
		.wb_clk_i   (clk),
		.rst_n_i    (rst_n),
		.host_cyc_i (host_cyc),
		.host_stb_i (host_stb),
		.host_we_i  (host_we),
		.host_adr_i (host_adr),
		.host_dat_i (host_dat),
		.host_sel_i (host_sel),
		.host_dat_o (host_rdat),
		.host_ack_o (host_ack),
		.host_err_o (host_err),
		.cmp_i      (cmp),
		.dac_code_o (dac_code),
		.busy_o     (busy)
	);

	// Comparator trips at or above the trip level
	assign cmp = (dac_code >= TRIP_LEVEL);

	bind wb_arbiter calsoc_assert u_assert (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.gnt_q    (gnt_q),
		.bus_cyc  (bus_o.cyc),
		.bus_stb  (bus_o.stb),
		.bus_ack  (bus_o.ack),
		.bus_err  (bus_o.err),
		.host_cyc (host_m.cyc),
		.host_stb (host_m.stb),
		.host_ack (host_m.ack),
		.mu_cyc   (mu_m.cyc),
		.mu_stb   (mu_m.stb),
		.mu_ack   (mu_m.ack)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_thr(input string name, input thr_t got, input thr_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////
	// Table construction
	////////////////////////////////////////
	task automatic add_test(input op_e op, input wb_adr_t adr, input wb_dat_t dat,
			input wb_sel_t sel, input wb_dat_t exp, input logic experr);
		op_q.push_back(op);
		adr_q.push_back(adr);
		dat_q.push_back(dat);
		sel_q.push_back(sel);
		exp_q.push_back(exp);
		experr_q.push_back(experr);
	endtask

	// Model keeps the disabled byte lanes
	task automatic ram_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				ram_model[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
		end
		add_test(OP_WR, adr, dat, sel, '0, 1'b0);
	endtask

	task automatic ram_read(input wb_adr_t adr);
		add_test(OP_RD, adr, '0, 4'hF, ram_model[adr[9:2]], 1'b0);
	endtask

	task automatic reg_write(input logic [31:0] ofs, input wb_dat_t dat);
		add_test(OP_WR, MU_BASE | ofs, dat, 4'hF, '0, 1'b0);
	endtask

	task automatic reg_read(input logic [31:0] ofs, input wb_dat_t exp);
		add_test(OP_RD, MU_BASE | ofs, '0, 4'hF, exp, 1'b0);
	endtask

	// Expected result words of one sweep
	task automatic expect_sweep(input thr_t start, input thr_t step, input int count,
			input wb_adr_t dest);
		thr_t    thr;
		wb_dat_t res;
		wb_adr_t a;
		thr = start;
		for (int i = 0; i < count; i++) begin
			res = '0;
			res[15:0] = thr;
			res[RESULT_CMP_BIT] = (thr >= TRIP_LEVEL);
			a = dest + wb_adr_t'(4 * i);
			ram_model[a[9:2]] = res;
			thr = thr + step;
		end
	endtask

	function automatic wb_sel_t partial_sel(input int i);
		case (i)
			0:       return 4'b0001;
			1:       return 4'b0110;
			2:       return 4'b1000;
			default: return 4'b0101;
		endcase
	endfunction

	task automatic build_table();
		wb_adr_t a;
		// State after reset
		reg_read(REG_STATUS, 32'h0);
		add_test(OP_THR, '0, '0, '0, 32'h0, 1'b0);
		add_test(OP_BUSY, '0, '0, '0, 32'h0, 1'b0);
		// RAM, full words first, then partial byte enables
		for (int pass = 0; pass < 3; pass++) begin
			for (int i = 0; i < 4; i++) begin
				a = (i == 3) ? 32'h3FC : wb_adr_t'(i * 32'h104);
				if (pass == 0)
					ram_write(a, wb_dat_t'($random(seed)), 4'hF);
				else if (pass == 1)
					ram_write(a, wb_dat_t'($random(seed)), partial_sel(i));
				else
					ram_read(a);
			end
		end
		// Unmapped region and unmapped register offset
		add_test(OP_WR, 32'h0200_0000, wb_dat_t'($random(seed)), 4'hF, '0, 1'b1);
		add_test(OP_RD, 32'h0200_0000, '0, 4'hF, '0, 1'b1);
		add_test(OP_RD, MU_BASE | 32'h40, '0, 4'hF, '0, 1'b1);
		add_test(OP_WR, MU_BASE | 32'h40, 32'h1, 4'hF, '0, 1'b1);
		// Sweep setup registers
		reg_write(REG_START, 32'h38);
		reg_write(REG_STEP, 32'h4);
		reg_write(REG_COUNT, 32'h6);
		reg_write(REG_DEST, 32'h80);
		reg_read(REG_START, 32'h38);
		reg_read(REG_STEP, 32'h4);
		reg_read(REG_COUNT, 32'h6);
		reg_read(REG_DEST, 32'h80);
		// First sweep with an idle host
		reg_write(REG_CTRL, 32'h1);
		add_test(OP_POLL, '0, '0, '0, 32'h2, 1'b0);
		expect_sweep(16'h38, 16'h4, 6, 32'h80);
		for (int i = 0; i < 6; i++)
			ram_read(32'h80 + wb_adr_t'(4 * i));
		add_test(OP_THR, '0, '0, '0, 32'h4C, 1'b0);
		add_test(OP_BUSY, '0, '0, '0, 32'h0, 1'b0);
		// Second sweep with host traffic on top
		for (int i = 0; i < 6; i++)
			ram_write(32'h80 + wb_adr_t'(4 * i), 32'h0, 4'hF);
		reg_write(REG_CTRL, 32'h1);
		// Sweep is running when the traffic starts
		add_test(OP_BUSY, '0, '0, '0, 32'h1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			a = 32'h180 + wb_adr_t'(4 * i);
			ram_write(a, wb_dat_t'($random(seed)), 4'hF);
			ram_read(a);
		end
		reg_read(REG_START, 32'h38);
		reg_read(REG_DEST, 32'h80);
		add_test(OP_POLL, '0, '0, '0, 32'h2, 1'b0);
		expect_sweep(16'h38, 16'h4, 6, 32'h80);
		for (int i = 0; i < 6; i++)
			ram_read(32'h80 + wb_adr_t'(4 * i));
		add_test(OP_THR, '0, '0, '0, 32'h4C, 1'b0);
	endtask

	////////////////////////////////////////
	// Host bus driver
	////////////////////////////////////////
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			input wb_sel_t sel, output wb_dat_t rdat, output logic ack, output logic err);
		@(posedge clk);
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we  <= we;
		host_adr <= adr;
		host_dat <= dat;
		host_sel <= sel;
		// Responses are sampled mid-cycle
		@(negedge clk);
		while (!(host_ack || host_err))
			@(negedge clk);
		rdat = host_rdat;
		ack  = host_ack;
		err  = host_err;
		@(posedge clk);
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we  <= 1'b0;
	endtask

	initial begin
		wb_dat_t rdat;
		logic    ack;
		logic    err;
		int      errs_before;
		seed     = 32'h9ea1;
		err_cnt  = 0;
		fail_cnt = 0;
		rst_n    <= 1'b0;
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we  <= 1'b0;
		host_adr <= '0;
		host_dat <= '0;
		host_sel <= '0;
		build_table();
		cycle_limit = 20 * op_q.size() + 2000;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < op_q.size(); i++) begin
			errs_before = err_cnt;
			case (op_q[i])
				OP_WR, OP_RD: begin
					bus_access(op_q[i] == OP_WR, adr_q[i], dat_q[i], sel_q[i], rdat, ack, err);
					check_bit("host_err_o", err, experr_q[i]);
					check_bit("host_ack_o", ack, !experr_q[i]);
					if (op_q[i] == OP_RD && !experr_q[i])
						check_dat("host_dat_o", rdat, exp_q[i]);
				end
				OP_POLL: begin
					rdat = '0;
					while (!rdat[1])
						bus_access(1'b0, MU_BASE | REG_STATUS, '0, 4'hF, rdat, ack, err);
					check_dat("status", rdat, exp_q[i]);
				end
				OP_THR: begin
					@(negedge clk);
					check_thr("dac_code_o", dac_code, exp_q[i][15:0]);
				end
				default: begin
					@(negedge clk);
					check_bit("busy_o", busy, exp_q[i][0]);
				end
			endcase
			if (err_cnt == errs_before) begin
				$display("test %0d %s adr %h pass", i, op_q[i].name(), adr_q[i]);
			end else begin
				fail_cnt++;
				$display("test %0d %s adr %h fail", i, op_q[i].name(), adr_q[i]);
			end
		end

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
			op_q.size(), op_q.size() - fail_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== calsoc_top.f ====
calsoc_pkg.sv
mu_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_decoder.sv
wb_ram.sv
measure_unit.sv
calsoc_top.sv
tb_clk_gen.sv
calsoc_assert.sv
calsoc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the calsoc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module calsoc_tb -f calsoc_top.f -o calsoc_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/calsoc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
